// ==== rtl/video_pkg.sv ====
package video_pkg;

  // coordinate width for x and y
  localparam int coord_w = 10;

  // horizontal timing, in pixels
  localparam logic [coord_w-1:0] h_active = 10'd640;
  localparam logic [coord_w-1:0] h_front  = 10'd16;
  localparam logic [coord_w-1:0] h_sync   = 10'd96;
  localparam logic [coord_w-1:0] h_back   = 10'd48;

  // vertical timing, in lines
  localparam logic [coord_w-1:0] v_active = 10'd480;
  localparam logic [coord_w-1:0] v_front  = 10'd10;
  localparam logic [coord_w-1:0] v_sync   = 10'd2;
  localparam logic [coord_w-1:0] v_back   = 10'd33;

endpackage

// ==== rtl/glyph_pkg.sv ====
package glyph_pkg;

  // 128 glyph slots of 16 rows each
  localparam int rom_addr_w = 11;

  localparam int glyph_w = 8;
  localparam int glyph_h = 16;

  localparam logic [6:0] sprite_base = 7'd127; // last slot holds the player

  // ascii codes used by the hud strings
  localparam logic [7:0] chr_digit0 = 8'h30;
  localparam logic [7:0] chr_space  = 8'h20;
  localparam logic [7:0] chr_cap_h  = 8'h48;
  localparam logic [7:0] chr_cap_l  = 8'h4c;
  localparam logic [7:0] chr_a      = 8'h61;
  localparam logic [7:0] chr_e      = 8'h65;
  localparam logic [7:0] chr_h      = 8'h68;
  localparam logic [7:0] chr_l      = 8'h6c;
  localparam logic [7:0] chr_t      = 8'h74;
  localparam logic [7:0] chr_v      = 8'h76;

  // one rom word, font or sprite view
  typedef union packed {
    logic [7:0]      font;   // bit 7 is the leftmost pixel
    logic [3:0][1:0] sprite; // entry 3 is the leftmost column
  } glyph_row_t;

  // sprite colours, index 0 is transparent
  localparam logic [23:0] palette_rgb [4] = '{
    24'h000000,
    24'hf8d030,
    24'h2050e0,
    24'he03020
  };

endpackage

// ==== rtl/raster_counter.sv ====
`timescale 1ns/100ps

module raster_counter #(
  parameter logic [video_pkg::coord_w-1:0] h_active = video_pkg::h_active,
  parameter logic [video_pkg::coord_w-1:0] h_front  = video_pkg::h_front,
  parameter logic [video_pkg::coord_w-1:0] h_sync   = video_pkg::h_sync,
  parameter logic [video_pkg::coord_w-1:0] h_back   = video_pkg::h_back,
  parameter logic [video_pkg::coord_w-1:0] v_active = video_pkg::v_active,
  parameter logic [video_pkg::coord_w-1:0] v_front  = video_pkg::v_front,
  parameter logic [video_pkg::coord_w-1:0] v_sync   = video_pkg::v_sync,
  parameter logic [video_pkg::coord_w-1:0] v_back   = video_pkg::v_back
) (
  input  logic                            Clk,
  input  logic                            arst_n,
  output logic                            phase,
  output logic [video_pkg::coord_w-1:0]   draw_x,
  output logic [video_pkg::coord_w-1:0]   draw_y,
  output logic                            draw_active,
  output logic                            hsync,
  output logic                            vsync
);

  localparam logic [video_pkg::coord_w-1:0] h_last = h_active + h_front + h_sync + h_back - 1'b1;
  localparam logic [video_pkg::coord_w-1:0] v_last = v_active + v_front + v_sync + v_back - 1'b1;
  localparam logic [video_pkg::coord_w-1:0] hs_beg = h_active + h_front;
  localparam logic [video_pkg::coord_w-1:0] vs_beg = v_active + v_front;

  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      phase  <= 1'b0;
      draw_x <= '0;
      draw_y <= '0;
    end else begin
      phase <= !phase;
      if (phase) begin // pixel ends on the odd cycle
        if (draw_x == h_last) begin
          draw_x <= '0;
          draw_y <= (draw_y == v_last) ? '0 : draw_y + 1'b1;
        end else begin
          draw_x <= draw_x + 1'b1;
        end
      end
    end
  end

  assign draw_active = (draw_x < h_active) && (draw_y < v_active);

  // active low sync pulses
  assign hsync = !((draw_x >= hs_beg) && (draw_x < hs_beg + h_sync));
  assign vsync = !((draw_y >= vs_beg) && (draw_y < vs_beg + v_sync));

endmodule

// ==== rtl/hud_text.sv ====
`timescale 1ns/100ps

module hud_text #(
  parameter int glyph_w = glyph_pkg::glyph_w,
  parameter int glyph_h = glyph_pkg::glyph_h
) (
  input  logic                             Clk,
  input  logic                             arst_n,
  input  logic                             phase,
  input  logic [video_pkg::coord_w-1:0]    draw_x,
  input  logic [video_pkg::coord_w-1:0]    draw_y,
  input  logic                             draw_active,
  input  logic [video_pkg::coord_w-1:0]    font_x,
  input  logic [video_pkg::coord_w-1:0]    font_y,
  input  logic [3:0]                       level,
  input  logic [3:0]                       health,
  input  glyph_pkg::glyph_row_t            text_data,
  input  logic                             text_ok,
  output logic [glyph_pkg::rom_addr_w-1:0] text_addr,
  output logic                             text_hit,
  output logic [23:0]                      text_rgb
);

  localparam int cw = video_pkg::coord_w;
  localparam int aw = glyph_pkg::rom_addr_w;
  localparam int bw = $clog2(glyph_w);
  localparam int rw = $clog2(glyph_h);
  localparam int line0_len = 7; // "Level N"
  localparam int line1_len = 8; // "Health N"

  logic [cw-1:0] dx;
  logic [cw-1:0] dy;
  logic [cw-1:0] col;
  logic          line;
  logic          in_box;
  logic [rw-1:0] row_idx;
  logic [bw-1:0] bit_col;
  logic [7:0]    chr;
  logic          hit_q;
  logic [bw-1:0] bit_q;

  always_comb begin
    dx      = draw_x - font_x;
    dy      = draw_y - font_y;
    col     = cw'(dx / glyph_w); // character column
    line    = (dy >= glyph_h);
    row_idx = rw'(dy % glyph_h);
    bit_col = bw'(dx % glyph_w);
    in_box  = draw_active && (draw_x >= font_x) && (draw_y >= font_y) &&
              (dy < 2 * glyph_h) && (col < (line ? line1_len : line0_len));

    case ({line, col[2:0]})
      4'b0_000: chr = glyph_pkg::chr_cap_l;
      4'b0_001: chr = glyph_pkg::chr_e;
      4'b0_010: chr = glyph_pkg::chr_v;
      4'b0_011: chr = glyph_pkg::chr_e;
      4'b0_100: chr = glyph_pkg::chr_l;
      4'b0_110: chr = glyph_pkg::chr_digit0 + {4'd0, level};
      4'b1_000: chr = glyph_pkg::chr_cap_h;
      4'b1_001: chr = glyph_pkg::chr_e;
      4'b1_010: chr = glyph_pkg::chr_a;
      4'b1_011: chr = glyph_pkg::chr_l;
      4'b1_100: chr = glyph_pkg::chr_t;
      4'b1_101: chr = glyph_pkg::chr_h;
      4'b1_111: chr = glyph_pkg::chr_digit0 + {4'd0, health};
      default:  chr = glyph_pkg::chr_space;
    endcase

    text_addr = aw'(chr) * aw'(glyph_h) + aw'(row_idx);
  end

  // context from the even cycle waits for the rom word
  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      hit_q    <= 1'b0;
      text_hit <= 1'b0;
    end else begin
      if (!phase) hit_q <= in_box;
      if (text_ok) text_hit <= hit_q;
    end
  end

  always_ff @(posedge Clk) begin
    if (!phase) bit_q <= bit_col;
    if (text_ok) begin
      // set bit is white, clear bit black
      text_rgb <= (hit_q && text_data.font[glyph_w-1-bit_q]) ? 24'hffffff : 24'h000000;
    end
  end

endmodule

// ==== rtl/player_sprite.sv ====
`timescale 1ns/100ps

module player_sprite #(
  parameter int glyph_w = glyph_pkg::glyph_w,
  parameter int glyph_h = glyph_pkg::glyph_h
) (
  input  logic                             Clk,
  input  logic                             arst_n,
  input  logic                             phase,
  input  logic [video_pkg::coord_w-1:0]    draw_x,
  input  logic [video_pkg::coord_w-1:0]    draw_y,
  input  logic                             draw_active,
  input  logic [video_pkg::coord_w-1:0]    player_x,
  input  logic [video_pkg::coord_w-1:0]    player_y,
  input  glyph_pkg::glyph_row_t            spr_data,
  input  logic                             spr_ok,
  output logic [glyph_pkg::rom_addr_w-1:0] spr_addr,
  output logic                             spr_hit,
  output logic [23:0]                      spr_rgb
);

  localparam int cw   = video_pkg::coord_w;
  localparam int aw   = glyph_pkg::rom_addr_w;
  localparam int bw   = $clog2(glyph_w);
  localparam int rw   = $clog2(glyph_h);
  localparam int half = glyph_w / 2;

  logic [cw-1:0] dx;
  logic [cw-1:0] dy;
  logic          in_box;
  logic          hit_q;
  logic [bw-1:0] col_q;
  logic [bw-1:0] mcol;
  logic [1:0]    pal_idx;

  always_comb begin
    dx       = draw_x - player_x;
    dy       = draw_y - player_y;
    in_box   = draw_active && (draw_x >= player_x) && (draw_y >= player_y) &&
               (dx < glyph_w) && (dy < glyph_h);
    spr_addr = aw'(glyph_pkg::sprite_base) * aw'(glyph_h) + aw'(dy[rw-1:0]);
  end

  // right half mirrors the left
  always_comb begin
    mcol    = (col_q < half) ? col_q : bw'(glyph_w - 1 - col_q);
    pal_idx = spr_data.sprite[half-1-mcol];
  end

  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      hit_q   <= 1'b0;
      spr_hit <= 1'b0;
    end else begin
      if (phase) hit_q <= in_box;
      if (spr_ok) spr_hit <= hit_q && (pal_idx != 2'd0);
    end
  end

  always_ff @(posedge Clk) begin
    if (phase) col_q <= dx[bw-1:0];
    if (spr_ok) spr_rgb <= glyph_pkg::palette_rgb[pal_idx];
  end

endmodule

// ==== rtl/rom_arbiter.sv ====
`timescale 1ns/100ps

module rom_arbiter (
  input  logic                             Clk,
  input  logic                             arst_n,
  input  logic                             phase,
  input  logic [glyph_pkg::rom_addr_w-1:0] text_addr,
  input  logic [glyph_pkg::rom_addr_w-1:0] spr_addr,
  input  glyph_pkg::glyph_row_t            rom_data,
  output logic [glyph_pkg::rom_addr_w-1:0] rom_addr,
  output glyph_pkg::glyph_row_t            text_data,
  output logic                             text_ok,
  output glyph_pkg::glyph_row_t            spr_data,
  output logic                             spr_ok
);

  logic busy_q; // a read is in flight
  logic slot_q; // owner of that read, 1 is the sprite

  // even slot to text, odd slot to sprite
  assign rom_addr = phase ? spr_addr : text_addr;

  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q <= 1'b0;
      slot_q <= 1'b0;
    end else begin
      busy_q <= 1'b1;
      slot_q <= phase;
    end
  end

  assign text_ok = busy_q && !slot_q;
  assign spr_ok  = busy_q && slot_q;

  // only the owner sees the word
  assign text_data = text_ok ? rom_data : '0;
  assign spr_data  = spr_ok ? rom_data : '0;

endmodule

// ==== rtl/glyph_rom.sv ====
`timescale 1ns/100ps

module glyph_rom (
  input  logic                             Clk,
  input  logic [glyph_pkg::rom_addr_w-1:0] rom_addr,
  output glyph_pkg::glyph_row_t            rom_data
);

  localparam int aw = glyph_pkg::rom_addr_w;

  logic [127:0] glyph; // 16 rows, row 0 in the top byte
  logic [3:0]   row;

  always_comb begin
    row = rom_addr[3:0];
    case (rom_addr[aw-1:4])
      glyph_pkg::chr_digit0 + 8'd0: glyph = 128'h0000_7CC6C6CEDEF6E6C6C67C_00000000;
      glyph_pkg::chr_digit0 + 8'd1: glyph = 128'h0000_1838781818181818187E_00000000;
      glyph_pkg::chr_digit0 + 8'd2: glyph = 128'h0000_7CC6060C183060C0C6FE_00000000;
      glyph_pkg::chr_digit0 + 8'd3: glyph = 128'h0000_7CC606063C060606C67C_00000000;
      glyph_pkg::chr_digit0 + 8'd4: glyph = 128'h0000_0C1C3C6CCCFE0C0C0C1E_00000000;
      glyph_pkg::chr_digit0 + 8'd5: glyph = 128'h0000_FEC0C0C0FC060606C67C_00000000;
      glyph_pkg::chr_digit0 + 8'd6: glyph = 128'h0000_3860C0C0FCC6C6C6C67C_00000000;
      glyph_pkg::chr_digit0 + 8'd7: glyph = 128'h0000_FEC606060C1830303030_00000000;
      glyph_pkg::chr_digit0 + 8'd8: glyph = 128'h0000_7CC6C6C67CC6C6C6C67C_00000000;
      glyph_pkg::chr_digit0 + 8'd9: glyph = 128'h0000_7CC6C6C67E0606060C78_00000000;
      glyph_pkg::chr_cap_h:         glyph = 128'h0000_C6C6C6C6FEC6C6C6C6C6_00000000;
      glyph_pkg::chr_cap_l:         glyph = 128'h0000_F06060606060606266FE_00000000;
      glyph_pkg::chr_a:             glyph = 128'h0000_000000780C7CCCCCCC76_00000000;
      glyph_pkg::chr_e:             glyph = 128'h0000_0000007CC6FEC0C0C67C_00000000;
      glyph_pkg::chr_h:             glyph = 128'h0000_E060606C7666666666E6_00000000;
      glyph_pkg::chr_l:             glyph = 128'h0000_3818181818181818183C_00000000;
      glyph_pkg::chr_t:             glyph = 128'h0000_103030FC30303030361C_00000000;
      glyph_pkg::chr_v:             glyph = 128'h0000_000000C6C6C6C66C3810_00000000;
      glyph_pkg::chr_space:         glyph = '0;
      // player, 2-bit palette indices for the left half
      glyph_pkg::sprite_base:       glyph = 128'h0005_151F1F052AAA8A8A0A3C_3030F000;
      default:                      glyph = '0;
    endcase
  end

  always_ff @(posedge Clk) begin
    rom_data.font <= glyph[(15 - row) * 8 +: 8];
  end

endmodule

// ==== rtl/overlay_top.sv ====
`timescale 1ns/100ps

module overlay_top (
  input  logic                          Clk,
  input  logic                          arst_n,
  input  logic [video_pkg::coord_w-1:0] font_x,
  input  logic [video_pkg::coord_w-1:0] font_y,
  input  logic [3:0]                    level,
  input  logic [3:0]                    health,
  input  logic [video_pkg::coord_w-1:0] player_x,
  input  logic [video_pkg::coord_w-1:0] player_y,
  output logic                          hsync,
  output logic                          vsync,
  output logic [23:0]                   rgb,
  output logic [video_pkg::coord_w-1:0] pix_x,
  output logic [video_pkg::coord_w-1:0] pix_y,
  output logic                          pix_valid
);

  logic                             phase;
  logic [video_pkg::coord_w-1:0]    draw_x;
  logic [video_pkg::coord_w-1:0]    draw_y;
  logic                             draw_active;
  logic [glyph_pkg::rom_addr_w-1:0] text_addr;
  logic [glyph_pkg::rom_addr_w-1:0] spr_addr;
  logic [glyph_pkg::rom_addr_w-1:0] rom_addr;
  glyph_pkg::glyph_row_t            rom_data;
  glyph_pkg::glyph_row_t            text_data;
  glyph_pkg::glyph_row_t            spr_data;
  logic                             text_ok;
  logic                             spr_ok;
  logic                             text_hit;
  logic                             spr_hit;
  logic [23:0]                      text_rgb;
  logic [23:0]                      spr_rgb;
  logic [23:0]                      merged;
  logic [video_pkg::coord_w-1:0]    x_d;
  logic [video_pkg::coord_w-1:0]    y_d;
  logic                             act_d;

  raster_counter #(
    .h_active (video_pkg::h_active),
    .h_front  (video_pkg::h_front),
    .h_sync   (video_pkg::h_sync),
    .h_back   (video_pkg::h_back),
    .v_active (video_pkg::v_active),
    .v_front  (video_pkg::v_front),
    .v_sync   (video_pkg::v_sync),
    .v_back   (video_pkg::v_back)
  ) i_raster_counter (
    .Clk, .arst_n, .phase, .draw_x, .draw_y, .draw_active, .hsync, .vsync
  );

  hud_text #(
    .glyph_w (glyph_pkg::glyph_w),
    .glyph_h (glyph_pkg::glyph_h)
  ) i_hud_text (
    .Clk, .arst_n, .phase, .draw_x, .draw_y, .draw_active, .font_x, .font_y,
    .level, .health, .text_data, .text_ok, .text_addr, .text_hit, .text_rgb
  );

  player_sprite #(
    .glyph_w (glyph_pkg::glyph_w),
    .glyph_h (glyph_pkg::glyph_h)
  ) i_player_sprite (
    .Clk, .arst_n, .phase, .draw_x, .draw_y, .draw_active, .player_x, .player_y,
    .spr_data, .spr_ok, .spr_addr, .spr_hit, .spr_rgb
  );

  rom_arbiter i_rom_arbiter (
    .Clk, .arst_n, .phase, .text_addr, .spr_addr, .rom_data,
    .rom_addr, .text_data, .text_ok, .spr_data, .spr_ok
  );

  glyph_rom i_glyph_rom (.Clk, .rom_addr, .rom_data);

  // sprite over text, black underneath
  assign merged = spr_hit ? spr_rgb : (text_hit ? text_rgb : 24'h000000);

  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      act_d     <= 1'b0;
      pix_valid <= 1'b0;
      rgb       <= '0;
    end else begin
      pix_valid <= phase && act_d; // both layers settled on this odd cycle
      if (phase) begin
        act_d <= draw_active;
        rgb   <= merged;
      end
    end
  end

  // coordinates trail by one pixel to meet the hits
  always_ff @(posedge Clk) begin
    if (phase) begin
      x_d   <= draw_x;
      y_d   <= draw_y;
      pix_x <= x_d;
      pix_y <= y_d;
    end
  end

endmodule

// ==== dv/overlay_sva.sv ====
`timescale 1ns/100ps

module overlay_sva (
  input logic                             Clk,
  input logic                             arst_n,
  input logic                             phase,
  input logic [glyph_pkg::rom_addr_w-1:0] rom_addr,
  input logic [glyph_pkg::rom_addr_w-1:0] text_addr,
  input logic [glyph_pkg::rom_addr_w-1:0] spr_addr,
  input logic                             text_ok,
  input logic                             spr_ok,
  input logic                             pix_valid,
  input logic [video_pkg::coord_w-1:0]    pix_x,
  input logic [video_pkg::coord_w-1:0]    pix_y
);

  int fail_cnt = 0; // failed assertions so far

  // even slot is text, odd slot is sprite
  a_text_slot: assert property (@(posedge Clk) disable iff (!arst_n)
    !phase |-> rom_addr == text_addr)
    else begin
      $error("rom_addr differs from text_addr in phase 0");
      fail_cnt = fail_cnt + 1;
    end

  a_spr_slot: assert property (@(posedge Clk) disable iff (!arst_n)
    phase |-> rom_addr == spr_addr)
    else begin
      $error("rom_addr differs from spr_addr in phase 1");
      fail_cnt = fail_cnt + 1;
    end

  a_one_owner: assert property (@(posedge Clk) disable iff (!arst_n)
    !(text_ok && spr_ok))
    else begin
      $error("text_ok and spr_ok high together");
      fail_cnt = fail_cnt + 1;
    end

  a_active_only: assert property (@(posedge Clk) disable iff (!arst_n)
    pix_valid |-> (pix_x < video_pkg::h_active) && (pix_y < video_pkg::v_active))
    else begin
      $error("pix_valid outside the active area");
      fail_cnt = fail_cnt + 1;
    end

  a_single_pulse: assert property (@(posedge Clk) disable iff (!arst_n)
    pix_valid |=> !pix_valid)
    else begin
      $error("pix_valid longer than one cycle");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind overlay_top overlay_sva i_overlay_sva (
  .Clk       (Clk),
  .arst_n    (arst_n),
  .phase     (phase),
  .rom_addr  (rom_addr),
  .text_addr (text_addr),
  .spr_addr  (spr_addr),
  .text_ok   (text_ok),
  .spr_ok    (spr_ok),
  .pix_valid (pix_valid),
  .pix_x     (pix_x),
  .pix_y     (pix_y)
);

// ==== dv/tb_overlay.sv ====
`timescale 1ns/100ps

module tb_overlay;

  localparam int cw          = video_pkg::coord_w;
  localparam int frame_limit = 900000; // a full frame is 840000 cycles
  localparam int line_limit  = 4000;

  logic            Clk;
  logic            arst_n;
  logic [cw-1:0]   font_x;
  logic [cw-1:0]   font_y;
  logic [3:0]      level;
  logic [3:0]      health;
  logic [cw-1:0]   player_x;
  logic [cw-1:0]   player_y;
  logic            hsync;
  logic            vsync;
  logic [23:0]     rgb;
  logic [cw-1:0]   pix_x;
  logic [cw-1:0]   pix_y;
  logic            pix_valid;

  integer          fd;
  integer          got;
  integer          n_tests;
  integer          n_fail;
  logic            stop_run;
  logic            done;
  logic [8*32-1:0] tok;
  logic [8*96-1:0] rest;

  overlay_top i_overlay_top (
    .Clk, .arst_n, .font_x, .font_y, .level, .health, .player_x, .player_y,
    .hsync, .vsync, .rgb, .pix_x, .pix_y, .pix_valid
  );

  initial begin
    Clk = 1'b0;
    forever #5 Clk = !Clk;
  end

  task automatic report(input logic [8*32-1:0] name, input logic ok);
    n_tests = n_tests + 1;
    if (ok) begin
      $display("PASS %0s", name);
    end else begin
      n_fail = n_fail + 1;
      $display("FAIL %0s", name);
    end
  endtask

  // outputs held idle for the 3 reset cycles
  task automatic check_reset;
    logic ok;
    ok = 1'b1;
    repeat (3) begin
      @(posedge Clk);
      #1;
      assert (pix_valid === 1'b0 && hsync === 1'b1 && vsync === 1'b1 && rgb === 24'h0)
      else begin
        $display("ERR @%0t: reset state pix_valid=%b hsync=%b vsync=%b rgb=%h",
                 $time, pix_valid, hsync, vsync, rgb);
        ok = 1'b0;
      end
    end
    arst_n = 1'b1;
    report("reset_state", ok);
  endtask

  task automatic count_line;
    integer cnt;
    integer cyc;
    logic   seen_next;
    cnt = 0;
    cyc = 0;
    seen_next = 1'b0;
    while (!seen_next && cyc < line_limit) begin
      @(negedge Clk);
      cyc = cyc + 1;
      if (pix_valid === 1'b1 && pix_y === 10'd1) seen_next = 1'b1;
      else if (pix_valid === 1'b1 && pix_y === 10'd0) cnt = cnt + 1;
    end
    if (!seen_next) begin
      $display("Timeout: no pixel of line 1 appeared after reset");
      stop_run = 1'b1;
    end else begin
      assert (cnt == 640) else
        $display("ERR @%0t: line 0 pixel count expected 640, got %0d", $time, cnt);
      report("line0_pixel_count", cnt == 640);
    end
  endtask

  // new settings only while vsync is low
  task automatic apply_settings;
    integer fx, fy, lv, hl, px, py, n, cyc;
    n = $fscanf(fd, "%d %d %d %d %d %d", fx, fy, lv, hl, px, py);
    if (n != 6) begin
      $display("Malformed settings record in the vector file");
      stop_run = 1'b1;
    end else begin
      cyc = 0;
      @(negedge Clk);
      while (vsync !== 1'b0 && cyc < frame_limit) begin
        @(negedge Clk);
        cyc = cyc + 1;
      end
      if (vsync !== 1'b0) begin
        $display("Timeout: vsync never went low to apply new settings");
        stop_run = 1'b1;
      end else begin
        @(posedge Clk);
        #1;
        font_x   = fx[cw-1:0];
        font_y   = fy[cw-1:0];
        level    = lv[3:0];
        health   = hl[3:0];
        player_x = px[cw-1:0];
        player_y = py[cw-1:0];
      end
    end
  endtask

  task automatic check_pixel;
    integer          x, y, n, cyc;
    logic [23:0]     exp_rgb;
    logic [8*32-1:0] name;
    logic            found;
    n = $fscanf(fd, "%d %d %h %s", x, y, exp_rgb, name);
    if (n != 4) begin
      $display("Malformed pixel record in the vector file");
      stop_run = 1'b1;
    end else begin
      found = 1'b0;
      cyc = 0;
      while (!found && cyc < frame_limit) begin
        @(negedge Clk);
        cyc = cyc + 1;
        found = (pix_valid === 1'b1) && (pix_x === x[cw-1:0]) && (pix_y === y[cw-1:0]);
      end
      if (!found) begin
        $display("Timeout: pixel (%0d,%0d) never appeared on pix_valid", x, y);
        stop_run = 1'b1;
      end else begin
        assert (rgb === exp_rgb) else
          $display("ERR @%0t: pixel (%0d,%0d) expected rgb %h, got %h",
                   $time, x, y, exp_rgb, rgb);
        report(name, rgb === exp_rgb);
      end
    end
  endtask

  initial begin
    arst_n   = 1'b0;
    font_x   = '0;
    font_y   = '0;
    level    = '0;
    health   = '0;
    player_x = '0;
    player_y = '0;
    n_tests  = 0;
    n_fail   = 0;
    stop_run = 1'b0;
    done     = 1'b0;
    fd = $fopen("dv/overlay_vectors.txt", "r");
    check_reset();
    count_line();
    if (fd == 0) begin
      $display("Could not open the vector file dv/overlay_vectors.txt");
      stop_run = 1'b1;
    end
    while (!done && !stop_run) begin
      got = $fscanf(fd, "%s", tok);
      if (got != 1) done = 1'b1;
      else if (tok == "#") got = $fgets(rest, fd); // comment line
      else if (tok == "S") apply_settings();
      else if (tok == "P") check_pixel();
      else begin
        $display("Unknown record %0s in the vector file", tok);
        stop_run = 1'b1;
      end
    end
    if (fd != 0) $fclose(fd);
    $display("Tests %0d, passed %0d, failed %0d, assertion failures %0d",
             n_tests, n_tests - n_fail, n_fail, i_overlay_top.i_overlay_sva.fail_cnt);
    if (n_fail == 0 && !stop_run && i_overlay_top.i_overlay_sva.fail_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== dv/overlay_vectors.txt ====
# S font_x font_y level health player_x player_y   (decimal, applied at next vsync)
# P x y rgb label   (x y decimal, rgb hex, expected value worked out from the glyph rows)
S 100 50 3 5 300 200
P 100 52 ffffff lvl_L_row2_set
P 104 52 000000 lvl_L_row2_clear
P 149 53 ffffff lvl_3_row3_set
P 151 53 000000 lvl_3_row3_clear
P 154 53 ffffff lvl_3_row3_right
P 148 56 000000 lvl_3_row6_clear
P 150 56 ffffff lvl_3_row6_set
P 106 61 ffffff lvl_L_row11_set
P 107 61 000000 lvl_L_row11_clear
P 102 68 000000 hp_H_row2_clear
P 160 68 ffffff hp_5_row2_set
P 163 68 000000 hp_5_row2_clear
P 101 72 ffffff hp_H_row6_set
P 161 72 ffffff hp_5_row6_set
P 162 72 000000 hp_5_row6_clear
P 300 203 000000 spr_row3_col0_clear
P 301 203 f8d030 spr_row3_col1
P 302 203 e03020 spr_row3_col2
P 306 203 f8d030 spr_row3_col6_mirror
P 307 203 000000 spr_row3_col7_mirror
P 299 207 000000 spr_left_outside
P 300 207 2050e0 spr_row7_col0
P 307 207 2050e0 spr_row7_col7
P 300 214 e03020 spr_row14_col0
P 302 214 000000 spr_row14_col2_clear
P 307 214 e03020 spr_row14_col7_mirror
# health 7, string one pixel right, sprite over the level digit
S 101 50 3 7 148 53
P 100 52 000000 shift_old_left_edge
P 104 52 ffffff shift_L_row2_set
P 105 52 000000 shift_L_row2_clear
P 153 54 f8d030 ovl_sprite_col5
P 154 54 ffffff ovl_clear_shows_text
P 155 54 ffffff ovl_clear_col7_text
P 148 56 000000 ovl_clear_over_space
P 151 56 e03020 ovl_sprite_wins_col3
P 154 56 f8d030 ovl_sprite_wins_col6
P 162 69 ffffff hp_7_row3_set
P 159 73 000000 hp_7_row7_clear
P 160 73 ffffff hp_7_row7_set

// ==== sources.f ====
rtl/video_pkg.sv
rtl/glyph_pkg.sv
rtl/raster_counter.sv
rtl/hud_text.sv
rtl/player_sprite.sv
rtl/rom_arbiter.sv
rtl/glyph_rom.sv
rtl/overlay_top.sv
dv/overlay_sva.sv
dv/tb_overlay.sv
